// ==== filelist.f ====
rtl/fetchPkg.sv
rtl/predictPkg.sv
rtl/fetchCtrl.sv
rtl/fetchIdAlloc.sv
rtl/branchTargetBuffer.sv
rtl/pcFile.sv
rtl/instrFetch.sv
dv/instrFetchTb.sv

// ==== Makefile ====
SIM      := verilator
TOP      := instrFetchTb
FILELIST := filelist.f
OBJDIR   := obj_dir
FLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJDIR)
PASS_MSG := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== dv/instrFetchTb.sv ====
`timescale 1ns/10ps

module instrFetchTb;

    localparam int          ID_W            = 4;
    localparam int          BTB_N           = 16;
    localparam logic [31:0] ENTRY_PC        = 32'h0000_1000;
    localparam int          CLK_PERIOD      = 20;
    localparam int          RESET_CYCLES    = 3;
    localparam int          SEQ_CYCLES      = 24;
    localparam int          BTB_CYCLES      = 40;
    localparam int          REDIR_CYCLES    = 40;
    localparam int          IRQ_CYCLES      = 21;
    localparam int          FLOW_CYCLES     = 68;
    localparam int          READ_CYCLES     = 30;
    localparam int          WATCHDOG_CYCLES = RESET_CYCLES + SEQ_CYCLES + BTB_CYCLES
                                            + REDIR_CYCLES + IRQ_CYCLES + FLOW_CYCLES
                                            + READ_CYCLES + 20;

    logic                  clk, rst, en, ready, irqPending;
    logic                  exValid, decValid, decWfi, btbWrValid, outValid;
    logic [ID_W-1:0]       exFetchId, decFetchId, comFetchId, rdAddr0, rdAddr1, outFetchId;
    logic [31:0]           exTarget, decTarget, btbWrPc, btbWrTarget;
    logic [31:0]           rdData0, rdData1, outPc, outPredTarget;
    logic [1:0]            outLastSlot;
    fetchPkg::fetchFault_t outFault;

    // Reference model state
    fetchPkg::fetchState_t mState;
    logic [31:0]           mPc;
    logic [ID_W-1:0]       mId;
    logic                  bValid [BTB_N];
    logic [23:0]           bTag [BTB_N];
    logic [1:0]            bSlot [BTB_N];
    logic [31:0]           bTarget [BTB_N];
    logic [31:0]           pcMem [2**ID_W];
    logic                  pcKnown [2**ID_W];

    // Expected outputs after the latest edge
    logic                  eValid, eFault, eRd0Known, eRd1Known;
    logic [31:0]           ePc, eTarget, eRd0, eRd1;
    logic [ID_W-1:0]       eId;
    logic [1:0]            eSlot;

    logic [31:0]           seed;
    int                    checks, errors, testErrors, pktCount, irqPktCount;

    instrFetch #(.FETCH_ID_W(ID_W), .BTB_ENTRIES(BTB_N), .ENTRY_PC(ENTRY_PC)) uut (
        .clk(clk), .rst(rst), .en(en), .ready(ready), .irqPending(irqPending),
        .exValid(exValid), .exFetchId(exFetchId), .exTarget(exTarget),
        .decValid(decValid), .decFetchId(decFetchId), .decTarget(decTarget), .decWfi(decWfi),
        .comFetchId(comFetchId), .btbWrValid(btbWrValid), .btbWrPc(btbWrPc),
        .btbWrTarget(btbWrTarget), .rdAddr0(rdAddr0), .rdAddr1(rdAddr1),
        .rdData0(rdData0), .rdData1(rdData1), .outValid(outValid), .outPc(outPc),
        .outFetchId(outFetchId), .outLastSlot(outLastSlot), .outPredTarget(outPredTarget),
        .outFault(outFault)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcgNext();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Defaults for one cycle, with the window tracking the next ID
    task automatic driveIdle();
        logic [31:0] r;
        r = lcgNext();
        en = 1'b1;
        ready = 1'b1;
        irqPending = 1'b0;
        exValid = 1'b0;
        decValid = 1'b0;
        decWfi = 1'b0;
        btbWrValid = 1'b0;
        comFetchId = mId;
        rdAddr0 = r[19:16];
        rdAddr1 = r[27:24];
    endtask

    task automatic modelStep();
        logic        allow;
        logic        irqF;
        logic        hit;
        logic [3:0]  idx;
        logic [1:0]  hitSlot;
        logic [31:0] hitTarget;
        logic [31:0] nextBlock;
        allow = (mState == fetchPkg::RUN) && en && ready && !exValid && !decValid
             && ((mId - comFetchId) != 4'hF);
        irqF = allow && irqPending;
        idx = mPc[7:4];
        hit = bValid[idx] && (bTag[idx] == mPc[31:8]) && (bSlot[idx] >= mPc[3:2]);
        hitSlot = bSlot[idx];
        hitTarget = bTarget[idx];
        nextBlock = {mPc[31:4], 4'h0} + 32'd16;
        eRd0 = pcMem[rdAddr0];
        eRd0Known = pcKnown[rdAddr0];
        eRd1 = pcMem[rdAddr1];
        eRd1Known = pcKnown[rdAddr1];
        eValid = allow;
        if (allow) begin
            ePc = mPc;
            eId = mId;
            eFault = irqF;
            eSlot = (hit && !irqF) ? hitSlot : 2'd3;
            eTarget = irqF ? mPc : (hit ? hitTarget : nextBlock);
            pcMem[mId] = mPc;
            pcKnown[mId] = 1'b1;
        end
        // Update lands after the lookup
        if (btbWrValid) begin
            bValid[btbWrPc[7:4]] = 1'b1;
            bTag[btbWrPc[7:4]] = btbWrPc[31:8];
            bSlot[btbWrPc[7:4]] = btbWrPc[3:2];
            bTarget[btbWrPc[7:4]] = btbWrTarget;
        end
        if (exValid) begin
            mPc = exTarget;
            mId = exFetchId + 4'd1;
            mState = fetchPkg::RUN;
        end else if (decValid) begin
            mPc = decTarget;
            mId = decFetchId + 4'd1;
            mState = decWfi ? fetchPkg::WAIT_IRQ : fetchPkg::RUN;
        end else begin
            if (allow) begin
                mId = mId + 4'd1;
            end
            if (allow && !irqF) begin
                mPc = hit ? hitTarget : nextBlock;
            end
            if (irqF) begin
                mState = fetchPkg::IRQ_SENT;
            end else if (mState == fetchPkg::WAIT_IRQ && irqPending) begin
                mState = fetchPkg::RUN;
            end
        end
    endtask

    task automatic checkOutputs();
        checkVal("outValid", 32'(outValid), 32'(eValid));
        if (eValid) begin
            checkVal("outPc", outPc, ePc);
            checkVal("outFetchId", 32'(outFetchId), 32'(eId));
            checkVal("outLastSlot", 32'(outLastSlot), 32'(eSlot));
            checkVal("outPredTarget", outPredTarget, eTarget);
            checkVal("outFault", 32'(outFault), 32'(eFault));
        end
        if (eRd0Known) begin
            checkVal("rdData0", rdData0, eRd0);
        end
        if (eRd1Known) begin
            checkVal("rdData1", rdData1, eRd1);
        end
        if (outValid) begin
            pktCount++;
        end
        if (outValid && outFault == fetchPkg::FAULT_IRQ) begin
            irqPktCount++;
        end
    endtask

    task automatic runCycle();
        @(posedge clk);
        modelStep();
        @(negedge clk);
        checkOutputs();
    endtask

    task automatic endTest(input string name);
        $display("test %s finished with %0d errors", name, errors - testErrors);
        testErrors = errors;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before all tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        logic [31:0]     r;
        logic [ID_W-1:0] frozenId;
        seed = 32'haabb;
        checks = 0;
        errors = 0;
        testErrors = 0;
        mState = fetchPkg::RUN;
        mPc = ENTRY_PC;
        mId = '0;
        eValid = 1'b0;
        eRd0Known = 1'b0;
        eRd1Known = 1'b0;
        for (int i = 0; i < BTB_N; i++) begin
            bValid[i] = 1'b0;
        end
        for (int i = 0; i < 2**ID_W; i++) begin
            pcKnown[i] = 1'b0;
        end
        rst = 1'b1;
        driveIdle();
        exFetchId = '0;
        decFetchId = '0;
        exTarget = '0;
        decTarget = '0;
        btbWrPc = '0;
        btbWrTarget = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (SEQ_CYCLES) begin
            driveIdle();
            runCycle();
        end
        endTest("sequential fetch");

        // Writes land on blocks a little ahead of the PC, or anywhere
        repeat (BTB_CYCLES) begin
            driveIdle();
            r = lcgNext();
            btbWrValid = r[0];
            btbWrPc = r[1] ? lcgNext() : {mPc[31:4] + {26'd0, r[3:2]}, r[5:4], 2'b00};
            btbWrTarget = 32'h0000_1000 | {22'd0, r[15:8], 2'b00};
            runCycle();
        end
        endTest("btb prediction");

        repeat (REDIR_CYCLES) begin
            driveIdle();
            r = lcgNext();
            exValid = (r[1:0] == 2'd0);
            decValid = (r[3:2] == 2'd0);
            exFetchId = r[7:4];
            decFetchId = r[11:8];
            exTarget = 32'h0000_1000 | {20'd0, r[21:12], 2'b00};
            decTarget = 32'h0000_2000 | {20'd0, r[31:22], 2'b00};
            runCycle();
        end
        endTest("redirects");

        driveIdle();
        decValid = 1'b1;
        decWfi = 1'b1;
        decFetchId = mId;
        decTarget = 32'h0000_2400;
        runCycle();
        pktCount = 0;
        irqPktCount = 0;
        repeat (5) begin
            driveIdle();
            runCycle();
        end
        checkVal("packets while parked", pktCount, 0);
        repeat (3) begin
            driveIdle();
            irqPending = 1'b1;
            runCycle();
        end
        repeat (5) begin
            driveIdle();
            runCycle();
        end
        checkVal("interrupt packets", irqPktCount, 1);
        checkVal("packets after interrupt", pktCount, 1);
        driveIdle();
        exValid = 1'b1;
        exFetchId = mId;
        exTarget = 32'h0000_3000;
        runCycle();
        repeat (6) begin
            driveIdle();
            runCycle();
        end
        endTest("interrupt and wfi");

        repeat (40) begin
            driveIdle();
            r = lcgNext();
            ready = r[0];
            en = (r[2:1] != 2'd0);
            runCycle();
        end
        frozenId = mId;
        pktCount = 0;
        repeat (20) begin
            driveIdle();
            comFetchId = frozenId;
            runCycle();
        end
        checkVal("packets with frozen window", pktCount, 15);
        repeat (8) begin
            driveIdle();
            comFetchId = frozenId + 4'd4;
            runCycle();
        end
        checkVal("packets after window moved", pktCount, 19);
        endTest("backpressure and window");

        repeat (READ_CYCLES) begin
            driveIdle();
            runCycle();
        end
        endTest("pc file reads");

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== rtl/instrFetch.sv ====
`timescale 1ns/10ps

module instrFetch #(
    parameter int          FETCH_ID_W  = 4,
    parameter int          BTB_ENTRIES = 16,
    parameter logic [31:0] ENTRY_PC    = 32'h0000_1000
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          en,
    input  logic                          ready,
    input  logic                          irqPending,
    input  logic                          exValid,
    input  logic [FETCH_ID_W-1:0]         exFetchId,
    input  logic [fetchPkg::PC_W-1:0]     exTarget,
    input  logic                          decValid,
    input  logic [FETCH_ID_W-1:0]         decFetchId,
    input  logic [fetchPkg::PC_W-1:0]     decTarget,
    input  logic                          decWfi,
    input  logic [FETCH_ID_W-1:0]         comFetchId,
    input  logic                          btbWrValid,
    input  logic [fetchPkg::PC_W-1:0]     btbWrPc,
    input  logic [fetchPkg::PC_W-1:0]     btbWrTarget,
    input  logic [FETCH_ID_W-1:0]         rdAddr0,
    input  logic [FETCH_ID_W-1:0]         rdAddr1,
    output logic [fetchPkg::PC_W-1:0]     rdData0,
    output logic [fetchPkg::PC_W-1:0]     rdData1,
    output logic                          outValid,
    output logic [fetchPkg::PC_W-1:0]     outPc,
    output logic [FETCH_ID_W-1:0]         outFetchId,
    output logic [predictPkg::OFFS_W-1:0] outLastSlot,
    output logic [fetchPkg::PC_W-1:0]     outPredTarget,
    output fetchPkg::fetchFault_t         outFault
);

    localparam logic [fetchPkg::PC_W-1:0] BLOCK_SIZE = fetchPkg::BLOCK_BYTES;

    logic [fetchPkg::PC_W-1:0]     pc;
    logic [fetchPkg::PC_W-1:0]     nextBlockPc;
    logic                          fetchAllow;
    logic                          irqFetch;
    fetchPkg::fetchState_t         ctrlState;
    logic [FETCH_ID_W-1:0]         fetchId;
    logic                          idFull;
    logic                          btbHit;
    logic [predictPkg::OFFS_W-1:0] btbSlot;
    logic [fetchPkg::PC_W-1:0]     btbTarget;

    // Start of the following aligned block
    assign nextBlockPc = (pc & ~(BLOCK_SIZE - 1'b1)) + BLOCK_SIZE;

    fetchCtrl ctrl (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .ready      (ready),
        .irqPending (irqPending),
        .exValid    (exValid),
        .decValid   (decValid),
        .decWfi     (decWfi),
        .idFull     (idFull),
        .fetchAllow (fetchAllow),
        .irqFetch   (irqFetch),
        .state      (ctrlState)
    );

    fetchIdAlloc #(.FETCH_ID_W(FETCH_ID_W)) idAlloc (
        .clk        (clk),
        .rst        (rst),
        .issue      (fetchAllow),
        .exValid    (exValid),
        .decValid   (decValid),
        .exFetchId  (exFetchId),
        .decFetchId (decFetchId),
        .comFetchId (comFetchId),
        .fetchId    (fetchId),
        .idFull     (idFull)
    );

    branchTargetBuffer #(.BTB_ENTRIES(BTB_ENTRIES)) btb (
        .clk       (clk),
        .rst       (rst),
        .wrValid   (btbWrValid),
        .lookupPc  (pc),
        .wrPc      (btbWrPc),
        .wrTarget  (btbWrTarget),
        .hit       (btbHit),
        .hitSlot   (btbSlot),
        .hitTarget (btbTarget)
    );

    pcFile #(.FETCH_ID_W(FETCH_ID_W)) pcf (
        .clk     (clk),
        .wrEn    (fetchAllow),
        .wrAddr  (fetchId),
        .wrData  (pc),
        .rdAddr0 (rdAddr0),
        .rdAddr1 (rdAddr1),
        .rdData0 (rdData0),
        .rdData1 (rdData1)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= ENTRY_PC;
        end else if (exValid) begin
            pc <= exTarget;
        end else if (decValid) begin
            pc <= decTarget;
        end else if (fetchAllow && !irqFetch) begin
            // Every BTB hit counts as taken
            pc <= btbHit ? btbTarget : nextBlockPc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= fetchAllow;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchAllow) begin
            outPc      <= pc;
            outFetchId <= fetchId;
            if (irqFetch) begin
                // Interrupt packet, no prediction attached
                outFault      <= fetchPkg::FAULT_IRQ;
                outLastSlot   <= predictPkg::SLOT_LAST;
                outPredTarget <= pc;
            end else begin
                outFault      <= fetchPkg::FAULT_NONE;
                outLastSlot   <= btbHit ? btbSlot : predictPkg::SLOT_LAST;
                outPredTarget <= btbHit ? btbTarget : nextBlockPc;
            end
        end
    end

    irqParksFetch: assert property (
        @(posedge clk) disable iff (rst)
        irqFetch |=> (ctrlState == fetchPkg::IRQ_SENT) && (pc == $past(pc))
    );

endmodule

// ==== rtl/pcFile.sv ====
`timescale 1ns/10ps

module pcFile #(
    parameter int FETCH_ID_W = 4
) (
    input  logic                      clk,
    input  logic                      wrEn,
    input  logic [FETCH_ID_W-1:0]     wrAddr,
    input  logic [fetchPkg::PC_W-1:0] wrData,
    input  logic [FETCH_ID_W-1:0]     rdAddr0,
    input  logic [FETCH_ID_W-1:0]     rdAddr1,
    output logic [fetchPkg::PC_W-1:0] rdData0,
    output logic [fetchPkg::PC_W-1:0] rdData1
);

    localparam int DEPTH = 2 ** FETCH_ID_W;

    logic [fetchPkg::PC_W-1:0] mem [DEPTH];

    // Reads see the value from before a same-cycle write
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
        rdData0 <= mem[rdAddr0];
        rdData1 <= mem[rdAddr1];
    end

endmodule

// ==== rtl/branchTargetBuffer.sv ====
`timescale 1ns/10ps

module branchTargetBuffer #(
    parameter int BTB_ENTRIES = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wrValid,
    input  logic [fetchPkg::PC_W-1:0]     lookupPc,
    input  logic [fetchPkg::PC_W-1:0]     wrPc,
    input  logic [fetchPkg::PC_W-1:0]     wrTarget,
    output logic                          hit,
    output logic [predictPkg::OFFS_W-1:0] hitSlot,
    output logic [fetchPkg::PC_W-1:0]     hitTarget
);

    localparam int IDX_W   = $clog2(BTB_ENTRIES);
    localparam int TAG_LSB = predictPkg::IDX_LSB + IDX_W;
    localparam int TAG_W   = fetchPkg::PC_W - TAG_LSB;

    logic [BTB_ENTRIES-1:0]          entryValid;
    logic [TAG_W-1:0]                entryTag    [BTB_ENTRIES];
    logic [predictPkg::OFFS_W-1:0]   entrySlot   [BTB_ENTRIES];
    logic [fetchPkg::PC_W-1:0]       entryTarget [BTB_ENTRIES];

    logic [IDX_W-1:0]                lookupIdx;
    logic [TAG_W-1:0]                lookupTag;
    logic [predictPkg::OFFS_W-1:0]   lookupSlot;
    logic [IDX_W-1:0]                wrIdx;

    assign lookupIdx  = lookupPc[predictPkg::IDX_LSB +: IDX_W];
    assign lookupTag  = lookupPc[TAG_LSB +: TAG_W];
    assign lookupSlot = lookupPc[predictPkg::SLOT_LSB +: predictPkg::OFFS_W];
    assign wrIdx      = wrPc[predictPkg::IDX_LSB +: IDX_W];

    // A branch before the entry point of the block was already passed
    assign hit = entryValid[lookupIdx]
              && (entryTag[lookupIdx] == lookupTag)
              && (entrySlot[lookupIdx] >= lookupSlot);
    assign hitSlot   = entrySlot[lookupIdx];
    assign hitTarget = entryTarget[lookupIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
        end else if (wrValid) begin
            entryValid[wrIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wrValid) begin
            entryTag[wrIdx]    <= wrPc[TAG_LSB +: TAG_W];
            entrySlot[wrIdx]   <= wrPc[predictPkg::SLOT_LSB +: predictPkg::OFFS_W];
            entryTarget[wrIdx] <= wrTarget;
        end
    end

endmodule

// ==== rtl/fetchIdAlloc.sv ====
`timescale 1ns/10ps

module fetchIdAlloc #(
    parameter int FETCH_ID_W = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issue,
    input  logic                  exValid,
    input  logic                  decValid,
    input  logic [FETCH_ID_W-1:0] exFetchId,
    input  logic [FETCH_ID_W-1:0] decFetchId,
    input  logic [FETCH_ID_W-1:0] comFetchId,
    output logic [FETCH_ID_W-1:0] fetchId,
    output logic                  idFull
);

    logic [FETCH_ID_W-1:0] inFlight;

    // Distance to the oldest uncommitted block wraps with the ID
    assign inFlight = fetchId - comFetchId;

    // One ID stays unused so full and empty can be told apart
    assign idFull = (inFlight == {FETCH_ID_W{1'b1}});

    always_ff @(posedge clk) begin
        if (rst) begin
            fetchId <= '0;
        end else if (exValid) begin
            fetchId <= exFetchId + 1'b1;
        end else if (decValid) begin
            fetchId <= decFetchId + 1'b1;
        end else if (issue) begin
            fetchId <= fetchId + 1'b1;
        end
    end

    noIssueWhenFull: assert property (
        @(posedge clk) disable iff (rst)
        idFull |-> !issue
    );

endmodule

// ==== rtl/fetchCtrl.sv ====
`timescale 1ns/10ps

module fetchCtrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  en,
    input  logic                  ready,
    input  logic                  irqPending,
    input  logic                  exValid,
    input  logic                  decValid,
    input  logic                  decWfi,
    input  logic                  idFull,
    output logic                  fetchAllow,
    output logic                  irqFetch,
    output fetchPkg::fetchState_t state
);

    logic redirect;

    assign redirect = exValid || decValid;

    assign fetchAllow = (state == fetchPkg::RUN) && en && ready && !redirect && !idFull;
    assign irqFetch   = fetchAllow && irqPending;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fetchPkg::RUN;
        end else if (exValid) begin
            // Execute redirect always restarts fetch
            state <= fetchPkg::RUN;
        end else if (decValid) begin
            state <= decWfi ? fetchPkg::WAIT_IRQ : fetchPkg::RUN;
        end else begin
            case (state)
                fetchPkg::RUN: begin
                    if (irqFetch) begin
                        state <= fetchPkg::IRQ_SENT;
                    end
                end
                fetchPkg::WAIT_IRQ: begin
                    if (irqPending) begin
                        state <= fetchPkg::RUN;
                    end
                end
                fetchPkg::IRQ_SENT: begin
                    // Only a redirect gets us out of here
                    state <= fetchPkg::IRQ_SENT;
                end
                default: begin
                    state <= fetchPkg::RUN;
                end
            endcase
        end
    end

    stateLegal: assert property (
        @(posedge clk) disable iff (rst)
        state inside {fetchPkg::RUN, fetchPkg::WAIT_IRQ, fetchPkg::IRQ_SENT}
    );

    // A WFI decode redirect keeps fetch off in the following cycle
    wfiParksFetch: assert property (
        @(posedge clk) disable iff (rst)
        (decValid && decWfi && !exValid) |=> !fetchAllow
    );

endmodule

// ==== rtl/predictPkg.sv ====
package predictPkg;

    // Instruction slot inside a fetch block
    localparam int OFFS_W = 2;

    // Slot of the final instruction in a block
    localparam logic [OFFS_W-1:0] SLOT_LAST = 2'd3;

    // PC bit where the slot field starts, below it sit the byte bits
    localparam int SLOT_LSB = 2;

    // BTB index starts right above the slot field, the tag above the index
    localparam int IDX_LSB = SLOT_LSB + OFFS_W;

endpackage

// ==== rtl/fetchPkg.sv ====
package fetchPkg;

    // Program counter width
    localparam int PC_W = 32;

    // One fetch block holds four 4-byte instructions
    localparam int BLOCK_BYTES = 16;

    // Frontend controller states
    typedef enum logic [1:0] {
        // Fetching normally
        RUN      = 2'd0,
        // Parked by a decode redirect until an interrupt shows up
        WAIT_IRQ = 2'd1,
        // Interrupt packet went out, waiting for the handler redirect
        IRQ_SENT = 2'd2
    } fetchState_t;

    // Fault carried with a fetched block
    typedef enum logic {
        FAULT_NONE = 1'b0,
        FAULT_IRQ  = 1'b1
    } fetchFault_t;

endpackage
